// File: hw/ddr_bridge_pkg.sv
/*
 * Widths, command and response codes, and payload structs of the bridge.
 * Each stage imports what it needs from here.
 */
package ddr_bridge_pkg;

  // ********************
  // Widths and depths
  // ********************
  localparam int AXI_ADDR_WIDTH = 32;
  localparam int AXI_DATA_WIDTH = 64;
  localparam int AXI_STRB_WIDTH = 8;
  // Byte window of the memory, higher address bits give SLVERR
  localparam int MEM_ADDR_BITS  = 29;
  localparam int APP_ADDR_WIDTH = 28;
  localparam int APP_DATA_WIDTH = 512;
  localparam int APP_MASK_WIDTH = 64;
  localparam int LANE_BITS      = 3;
  // Completion queue size, also the limit on commands in flight
  localparam int CPL_DEPTH      = 4;
  localparam int CPL_PTR_BITS   = $clog2(CPL_DEPTH);

  // ********************
  // Codes
  // ********************
  localparam logic [2:0] APP_CMD_WRITE = 3'd0;
  localparam logic [2:0] APP_CMD_READ  = 3'd1;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Request as accepted on the AXI4-Lite side
  typedef struct packed {
    logic                      write;
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [AXI_STRB_WIDTH-1:0] strb;
  } axi_req_t;

  // Request mapped onto the controller line
  typedef struct packed {
    logic                      write;
    logic                      err;
    logic [APP_ADDR_WIDTH-1:0] addr;
    logic [LANE_BITS-1:0]      lane;
    logic [APP_DATA_WIDTH-1:0] data;
    logic [APP_MASK_WIDTH-1:0] mask;
  } app_req_t;

  typedef struct packed {
    logic                      write;
    logic [1:0]                resp;
    logic [AXI_DATA_WIDTH-1:0] data;
  } axi_rsp_t;

endpackage

// File: hw/mem_req_if.sv
`timescale 1ns/100ps
/*
 * Valid/ready link carrying one payload between two bridge stages.
 * The payload type is chosen where the link is instantiated.
 */
interface mem_req_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  // Held stable while valid is high and ready is low
  payload_t payload;

  modport master (
    output valid,
    output payload,
    input  ready
  );

  modport slave (
    input  valid,
    input  payload,
    output ready
  );

endinterface

// File: hw/pipe_skid.sv
`timescale 1ns/100ps
/*
 * Two-entry buffer for any payload type that cuts the ready path.
 * Sits on the request path and on the response path of the bridge.
 */
module pipe_skid #(
  parameter type payload_t = logic
) (
  input  logic      c0_ddr4_clk,
  input  logic      rst_i,
  mem_req_if.slave  in_if,
  mem_req_if.master out_if
);

  payload_t   buf_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  // Ready comes from the fill level only, never from the consumer
  assign in_if.ready    = (count_q != 2'd2);
  assign out_if.valid   = (count_q != 2'd0);
  assign out_if.payload = buf_q[rd_ptr_q];

  assign push = in_if.valid && in_if.ready;
  assign pop  = out_if.valid && out_if.ready;

  always_ff @(posedge c0_ddr4_clk) begin
    if (rst_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (push) begin
      buf_q[wr_ptr_q] <= in_if.payload;
    end
  end

  // A stalled head entry reaches the consumer unchanged
  a_stall_stable : assert property (@(posedge c0_ddr4_clk) disable iff (rst_i)
    out_if.valid && !out_if.ready |=> out_if.valid && $stable(out_if.payload));

endmodule

// File: hw/axil_req_front.sv
`timescale 1ns/100ps
/*
 * AXI4-Lite slave front end. Pairs AW with W, arbitrates against AR and
 * sends each response back on B or R according to its write flag.
 */
module axil_req_front (
  input  logic                                      c0_ddr4_clk,
  input  logic                                      rst_i,
  input  logic                                      calib_i,
  input  logic [ddr_bridge_pkg::AXI_ADDR_WIDTH-1:0] s_axil_awaddr_i,
  input  logic                                      s_axil_awvalid_i,
  output logic                                      s_axil_awready_o,
  input  logic [ddr_bridge_pkg::AXI_DATA_WIDTH-1:0] s_axil_wdata_i,
  input  logic [ddr_bridge_pkg::AXI_STRB_WIDTH-1:0] s_axil_wstrb_i,
  input  logic                                      s_axil_wvalid_i,
  output logic                                      s_axil_wready_o,
  input  logic [ddr_bridge_pkg::AXI_ADDR_WIDTH-1:0] s_axil_araddr_i,
  input  logic                                      s_axil_arvalid_i,
  output logic                                      s_axil_arready_o,
  mem_req_if.master                                 req,
  mem_req_if.slave                                  rsp,
  output logic [1:0]                                s_axil_bresp_o,
  output logic                                      s_axil_bvalid_o,
  input  logic                                      s_axil_bready_i,
  output logic [ddr_bridge_pkg::AXI_DATA_WIDTH-1:0] s_axil_rdata_o,
  output logic [1:0]                                s_axil_rresp_o,
  output logic                                      s_axil_rvalid_o,
  input  logic                                      s_axil_rready_i
);
  import ddr_bridge_pkg::*;

  axi_req_t req_q;
  logic     req_valid_q;
  logic     calib_q;
  logic     read_first_q;
  logic     slot_free;
  logic     wr_pend;
  logic     take_wr;
  logic     take_rd;

  // ********************
  // Request side
  // ********************
  // Calibration must be high now and already seen since leaving reset
  assign slot_free = calib_i && calib_q && (!req_valid_q || req.ready);
  assign wr_pend   = s_axil_awvalid_i && s_axil_wvalid_i;
  assign take_wr   = slot_free && wr_pend && !(s_axil_arvalid_i && read_first_q);
  assign take_rd   = slot_free && s_axil_arvalid_i && !(wr_pend && !read_first_q);

  // AW and W are taken together in one cycle
  assign s_axil_awready_o = take_wr;
  assign s_axil_wready_o  = take_wr;
  assign s_axil_arready_o = take_rd;

  assign req.valid   = req_valid_q;
  assign req.payload = req_q;

  always_ff @(posedge c0_ddr4_clk) begin
    if (rst_i) begin
      calib_q      <= 1'b0;
      read_first_q <= 1'b0;
      req_valid_q  <= 1'b0;
    end else begin
      calib_q <= calib_i;
      if (take_wr || take_rd) begin
        req_valid_q <= 1'b1;
      end else if (req.ready) begin
        req_valid_q <= 1'b0;
      end
      // Priority flips after every read/write conflict
      if (slot_free && wr_pend && s_axil_arvalid_i) begin
        read_first_q <= ~read_first_q;
      end
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (take_wr) begin
      req_q.write <= 1'b1;
      req_q.addr  <= s_axil_awaddr_i;
      req_q.data  <= s_axil_wdata_i;
      req_q.strb  <= s_axil_wstrb_i;
    end else if (take_rd) begin
      req_q.write <= 1'b0;
      req_q.addr  <= s_axil_araddr_i;
      req_q.data  <= '0;
      req_q.strb  <= '0;
    end
  end

  // ********************
  // Response side
  // ********************
  assign s_axil_bvalid_o = rsp.valid && rsp.payload.write;
  assign s_axil_rvalid_o = rsp.valid && !rsp.payload.write;
  assign s_axil_bresp_o  = rsp.payload.resp;
  assign s_axil_rresp_o  = rsp.payload.resp;
  assign s_axil_rdata_o  = rsp.payload.data;
  assign rsp.ready       = rsp.payload.write ? s_axil_bready_i : s_axil_rready_i;

  // A stalled B response stays on B and never shows up on R
  a_b_hold : assert property (@(posedge c0_ddr4_clk) disable iff (rst_i)
    s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o && !s_axil_rvalid_o);

endmodule

// File: hw/app_addr_map.sv
`timescale 1ns/100ps
/*
 * Registered stage that maps an AXI byte address onto a controller line,
 * places the 64-bit word in its lane and builds the byte mask.
 */
module app_addr_map (
  input  logic      c0_ddr4_clk,
  input  logic      rst_i,
  mem_req_if.slave  in_if,
  mem_req_if.master out_if
);
  import ddr_bridge_pkg::*;

  app_req_t                  out_q;
  logic                      out_valid_q;
  logic [AXI_ADDR_WIDTH-1:0] addr;
  logic [LANE_BITS-1:0]      lane;

  assign addr = in_if.payload.addr;
  // Lane is the 64-bit word inside the 64-byte line
  assign lane = addr[LANE_BITS+2:3];

  assign in_if.ready    = !out_valid_q || out_if.ready;
  assign out_if.valid   = out_valid_q;
  assign out_if.payload = out_q;

  always_ff @(posedge c0_ddr4_clk) begin
    if (rst_i) begin
      out_valid_q <= 1'b0;
    end else if (in_if.ready) begin
      out_valid_q <= in_if.valid;
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (in_if.valid && in_if.ready) begin
      out_q.write <= in_if.payload.write;
      // Anything above the memory window is answered with SLVERR
      out_q.err   <= |addr[AXI_ADDR_WIDTH-1:MEM_ADDR_BITS];
      // Byte address bits 28:1, low five cleared to align on the line
      out_q.addr  <= {addr[MEM_ADDR_BITS-1:6], 5'b0};
      out_q.lane  <= lane;
      out_q.data  <= APP_DATA_WIDTH'(in_if.payload.data) << (lane * AXI_DATA_WIDTH);
      // Masked bytes are the other lanes and unstrobed bytes of this one
      out_q.mask  <= ~(APP_MASK_WIDTH'(in_if.payload.strb) << (lane * AXI_STRB_WIDTH));
    end
  end

endmodule

// File: hw/app_cmd_issue.sv
`timescale 1ns/100ps
/*
 * Issues mapped requests on the controller's native interface and keeps
 * an in-order completion queue that turns them back into AXI responses.
 */
module app_cmd_issue (
  input  logic                                      c0_ddr4_clk,
  input  logic                                      rst_i,
  mem_req_if.slave                                  in_if,
  mem_req_if.master                                 rsp,
  output logic [ddr_bridge_pkg::APP_ADDR_WIDTH-1:0] app_addr_o,
  output logic [2:0]                                app_cmd_o,
  output logic                                      app_en_o,
  input  logic                                      app_rdy_i,
  output logic [ddr_bridge_pkg::APP_DATA_WIDTH-1:0] app_wdf_data_o,
  output logic [ddr_bridge_pkg::APP_MASK_WIDTH-1:0] app_wdf_mask_o,
  output logic                                      app_wdf_wren_o,
  output logic                                      app_wdf_end_o,
  input  logic                                      app_wdf_rdy_i,
  input  logic [ddr_bridge_pkg::APP_DATA_WIDTH-1:0] app_rd_data_i,
  input  logic                                      app_rd_data_valid_i
);
  import ddr_bridge_pkg::*;

  logic                      q_write [CPL_DEPTH];
  logic                      q_err   [CPL_DEPTH];
  logic                      q_done  [CPL_DEPTH];
  logic [LANE_BITS-1:0]      q_lane  [CPL_DEPTH];
  logic [AXI_DATA_WIDTH-1:0] q_data  [CPL_DEPTH];
  logic [CPL_PTR_BITS-1:0]   wr_ptr_q;
  logic [CPL_PTR_BITS-1:0]   rd_ptr_q;
  logic [CPL_PTR_BITS:0]     count_q;
  logic [CPL_PTR_BITS-1:0]   rd_slot;
  logic                      rd_hit;
  logic                      space;
  logic                      can_issue;
  logic                      push;
  logic                      pop;

  // ********************
  // Command issue
  // ********************
  assign space     = (count_q != CPL_DEPTH);
  // Writes need both the command and the write-data FIFO ready
  assign can_issue = app_rdy_i && (!in_if.payload.write || app_wdf_rdy_i);

  assign app_en_o       = in_if.valid && space && !in_if.payload.err && can_issue;
  assign app_cmd_o      = in_if.payload.write ? APP_CMD_WRITE : APP_CMD_READ;
  assign app_addr_o     = in_if.payload.addr;
  assign app_wdf_data_o = in_if.payload.data;
  assign app_wdf_mask_o = in_if.payload.mask;
  assign app_wdf_wren_o = app_en_o && in_if.payload.write;
  assign app_wdf_end_o  = app_wdf_wren_o;

  // Error requests only take a queue slot, nothing goes to the controller
  assign in_if.ready = space && (in_if.payload.err || can_issue);
  assign push        = in_if.valid && in_if.ready;
  assign pop         = rsp.valid && rsp.ready;

  // Oldest pending read, searched from the queue head
  always_comb begin
    logic [CPL_PTR_BITS-1:0] idx;
    rd_hit  = 1'b0;
    rd_slot = rd_ptr_q;
    for (int i = 0; i < CPL_DEPTH; i++) begin
      idx = rd_ptr_q + CPL_PTR_BITS'(i);
      if (!rd_hit && (i < int'(count_q)) && !q_write[idx] && !q_err[idx] && !q_done[idx]) begin
        rd_hit  = 1'b1;
        rd_slot = idx;
      end
    end
  end

  // ********************
  // Completion queue
  // ********************
  always_ff @(posedge c0_ddr4_clk) begin
    if (push) begin
      q_write[wr_ptr_q] <= in_if.payload.write;
      q_err[wr_ptr_q]   <= in_if.payload.err;
      q_lane[wr_ptr_q]  <= in_if.payload.lane;
      q_done[wr_ptr_q]  <= in_if.payload.write || in_if.payload.err;
      q_data[wr_ptr_q]  <= '0;
    end
    if (app_rd_data_valid_i && rd_hit) begin
      q_done[rd_slot] <= 1'b1;
      q_data[rd_slot] <= app_rd_data_i[q_lane[rd_slot]*AXI_DATA_WIDTH +: AXI_DATA_WIDTH];
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (CPL_PTR_BITS+1)'(push) - (CPL_PTR_BITS+1)'(pop);
    end
  end

  // Head slot leaves once it is complete
  assign rsp.valid        = (count_q != '0) && q_done[rd_ptr_q];
  assign rsp.payload.write = q_write[rd_ptr_q];
  assign rsp.payload.resp  = q_err[rd_ptr_q] ? RESP_SLVERR : RESP_OKAY;
  assign rsp.payload.data  = q_data[rd_ptr_q];

  // Controller returns data only for reads issued earlier
  a_rd_pending : assert property (@(posedge c0_ddr4_clk) disable iff (rst_i)
    app_rd_data_valid_i |-> rd_hit);

endmodule

// File: hw/ddr_bridge.sv
`timescale 1ns/100ps
/*
 * AXI4-Lite to DDR4 native interface bridge, top level in the UI clock.
 * Chains front end, skid buffers, address map and command issue.
 */
module ddr_bridge (
  input  logic                                      c0_ddr4_clk,
  input  logic                                      reset_i,
  input  logic                                      init_calib_complete_i,
  input  logic [ddr_bridge_pkg::AXI_ADDR_WIDTH-1:0] s_axil_awaddr_i,
  input  logic                                      s_axil_awvalid_i,
  output logic                                      s_axil_awready_o,
  input  logic [ddr_bridge_pkg::AXI_DATA_WIDTH-1:0] s_axil_wdata_i,
  input  logic [ddr_bridge_pkg::AXI_STRB_WIDTH-1:0] s_axil_wstrb_i,
  input  logic                                      s_axil_wvalid_i,
  output logic                                      s_axil_wready_o,
  output logic [1:0]                                s_axil_bresp_o,
  output logic                                      s_axil_bvalid_o,
  input  logic                                      s_axil_bready_i,
  input  logic [ddr_bridge_pkg::AXI_ADDR_WIDTH-1:0] s_axil_araddr_i,
  input  logic                                      s_axil_arvalid_i,
  output logic                                      s_axil_arready_o,
  output logic [ddr_bridge_pkg::AXI_DATA_WIDTH-1:0] s_axil_rdata_o,
  output logic [1:0]                                s_axil_rresp_o,
  output logic                                      s_axil_rvalid_o,
  input  logic                                      s_axil_rready_i,
  output logic [ddr_bridge_pkg::APP_ADDR_WIDTH-1:0] app_addr_o,
  output logic [2:0]                                app_cmd_o,
  output logic                                      app_en_o,
  input  logic                                      app_rdy_i,
  output logic [ddr_bridge_pkg::APP_DATA_WIDTH-1:0] app_wdf_data_o,
  output logic [ddr_bridge_pkg::APP_MASK_WIDTH-1:0] app_wdf_mask_o,
  output logic                                      app_wdf_wren_o,
  output logic                                      app_wdf_end_o,
  input  logic                                      app_wdf_rdy_i,
  input  logic [ddr_bridge_pkg::APP_DATA_WIDTH-1:0] app_rd_data_i,
  input  logic                                      app_rd_data_valid_i
);
  import ddr_bridge_pkg::*;

  logic stage_rst;

  // Controller reset registered once into the bridge's own reset
  always_ff @(posedge c0_ddr4_clk) begin
    stage_rst <= reset_i;
  end

  // Index 0 feeds a skid buffer, index 1 leaves it
  mem_req_if #(.payload_t(axi_req_t)) req_if [2] ();
  mem_req_if #(.payload_t(app_req_t)) app_if ();
  mem_req_if #(.payload_t(axi_rsp_t)) rsp_if [2] ();

  axil_req_front u_front (
    .c0_ddr4_clk      (c0_ddr4_clk),
    .rst_i            (stage_rst),
    .calib_i          (init_calib_complete_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .req              (req_if[0]),
    .rsp              (rsp_if[1]),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i)
  );

  pipe_skid #(.payload_t(axi_req_t)) u_req_skid (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_i       (stage_rst),
    .in_if       (req_if[0]),
    .out_if      (req_if[1])
  );

  app_addr_map u_map (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_i       (stage_rst),
    .in_if       (req_if[1]),
    .out_if      (app_if)
  );

  app_cmd_issue u_issue (
    .c0_ddr4_clk         (c0_ddr4_clk),
    .rst_i               (stage_rst),
    .in_if               (app_if),
    .rsp                 (rsp_if[0]),
    .app_addr_o          (app_addr_o),
    .app_cmd_o           (app_cmd_o),
    .app_en_o            (app_en_o),
    .app_rdy_i           (app_rdy_i),
    .app_wdf_data_o      (app_wdf_data_o),
    .app_wdf_mask_o      (app_wdf_mask_o),
    .app_wdf_wren_o      (app_wdf_wren_o),
    .app_wdf_end_o       (app_wdf_end_o),
    .app_wdf_rdy_i       (app_wdf_rdy_i),
    .app_rd_data_i       (app_rd_data_i),
    .app_rd_data_valid_i (app_rd_data_valid_i)
  );

  pipe_skid #(.payload_t(axi_rsp_t)) u_rsp_skid (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_i       (stage_rst),
    .in_if       (rsp_if[0]),
    .out_if      (rsp_if[1])
  );

endmodule

// File: verification/bridge_checker.sv
`timescale 1ns/100ps
/*
 * Watches the bridge ports, keeps a reference memory and ordered lists of
 * expected responses and controller commands, and counts mismatches.
 */
module bridge_checker (
  input  logic         c0_ddr4_clk,
  input  logic         reset_i,
  input  logic         init_calib_complete_i,
  input  logic [31:0]  s_axil_awaddr_i,
  input  logic         s_axil_awvalid_i,
  input  logic         s_axil_awready_o,
  input  logic [63:0]  s_axil_wdata_i,
  input  logic [7:0]   s_axil_wstrb_i,
  input  logic         s_axil_wvalid_i,
  input  logic         s_axil_wready_o,
  input  logic [1:0]   s_axil_bresp_o,
  input  logic         s_axil_bvalid_o,
  input  logic         s_axil_bready_i,
  input  logic [31:0]  s_axil_araddr_i,
  input  logic         s_axil_arvalid_i,
  input  logic         s_axil_arready_o,
  input  logic [63:0]  s_axil_rdata_o,
  input  logic [1:0]   s_axil_rresp_o,
  input  logic         s_axil_rvalid_o,
  input  logic         s_axil_rready_i,
  input  logic [27:0]  app_addr_o,
  input  logic [2:0]   app_cmd_o,
  input  logic         app_en_o,
  input  logic         app_rdy_i,
  input  logic [511:0] app_wdf_data_o,
  input  logic [63:0]  app_wdf_mask_o,
  input  logic         app_wdf_wren_o,
  input  logic         app_wdf_end_o,
  input  logic         app_wdf_rdy_i,
  output int           errors_o,
  output int           pending_o
);
  import ddr_bridge_pkg::*;

  typedef struct {
    logic        write;
    logic [1:0]  resp;
    logic [63:0] data;
  } exp_rsp_t;

  typedef struct {
    logic        write;
    logic [31:0] addr;
    logic [63:0] data;
    logic [7:0]  strb;
  } exp_cmd_t;

  // Reference memory of 64-bit words, keyed by byte address bits 28:3
  logic [63:0] ref_mem [logic [25:0]];
  exp_rsp_t    rsp_q [$];
  exp_cmd_t    cmd_q [$];
  int          errors = 0;
  int          reset_cycles = 0;

  task automatic flag_error(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  function automatic logic in_window(input logic [31:0] a);
    return a[31:29] == 3'b000;
  endfunction

  function automatic logic [63:0] read_word(input logic [31:0] a);
    return ref_mem.exists(a[28:3]) ? ref_mem[a[28:3]] : 64'h0;
  endfunction

  // Byte mask as the controller expects it: high means keep the old byte
  function automatic logic [63:0] lane_mask(input logic [31:0] a, input logic [7:0] strb);
    logic [63:0] m;
    for (int b = 0; b < 64; b++) begin
      m[b] = !((b / 8 == int'(a[5:3])) && strb[b % 8]);
    end
    return m;
  endfunction

  // ********************
  // Request side
  // ********************
  always @(negedge c0_ddr4_clk) begin
    exp_cmd_t    ec;
    logic [63:0] word;
    logic [27:0] line;
    if (reset_i) begin
      reset_cycles++;
      if (reset_cycles > 2 && (s_axil_bvalid_o || s_axil_rvalid_o || app_en_o ||
          app_wdf_wren_o || s_axil_awready_o || s_axil_wready_o || s_axil_arready_o)) begin
        flag_error("valid, ready or enable output high during reset");
      end
    end else begin
      if (!init_calib_complete_i &&
          (s_axil_awready_o || s_axil_wready_o || s_axil_arready_o || app_en_o)) begin
        flag_error("ready or app_en_o high before calibration completed");
      end
      if ((s_axil_awvalid_i && s_axil_awready_o) != (s_axil_wvalid_i && s_axil_wready_o)) begin
        flag_error("AW and W not accepted in the same cycle");
      end
      if (s_axil_awvalid_i && s_axil_awready_o && s_axil_arvalid_i && s_axil_arready_o) begin
        flag_error("AW and AR accepted in the same cycle");
      end
      if (s_axil_awvalid_i && s_axil_awready_o) begin
        if (in_window(s_axil_awaddr_i)) begin
          word = read_word(s_axil_awaddr_i);
          for (int i = 0; i < 8; i++) begin
            if (s_axil_wstrb_i[i]) word[i*8 +: 8] = s_axil_wdata_i[i*8 +: 8];
          end
          ref_mem[s_axil_awaddr_i[28:3]] = word;
          rsp_q.push_back('{write: 1'b1, resp: RESP_OKAY, data: 64'h0});
          cmd_q.push_back('{write: 1'b1, addr: s_axil_awaddr_i, data: s_axil_wdata_i,
                            strb: s_axil_wstrb_i});
        end else begin
          rsp_q.push_back('{write: 1'b1, resp: RESP_SLVERR, data: 64'h0});
        end
      end
      if (s_axil_arvalid_i && s_axil_arready_o) begin
        if (in_window(s_axil_araddr_i)) begin
          rsp_q.push_back('{write: 1'b0, resp: RESP_OKAY, data: read_word(s_axil_araddr_i)});
          cmd_q.push_back('{write: 1'b0, addr: s_axil_araddr_i, data: 64'h0, strb: 8'h0});
        end else begin
          rsp_q.push_back('{write: 1'b0, resp: RESP_SLVERR, data: 64'h0});
        end
      end

      // ********************
      // Controller side
      // ********************
      if ((app_wdf_wren_o || app_wdf_end_o) && !app_en_o) begin
        flag_error("write data strobed without a command");
      end
      if (app_en_o && app_rdy_i) begin
        if (cmd_q.size() == 0) begin
          flag_error("controller command with no in-range request behind it");
        end else begin
          ec = cmd_q.pop_front();
          line = ec.addr[28:1];
          line[4:0] = 5'b0;
          if (app_cmd_o != (ec.write ? APP_CMD_WRITE : APP_CMD_READ) || app_addr_o != line) begin
            flag_error($sformatf("command %0d at %h, expected write=%0b at %h",
                                 app_cmd_o, app_addr_o, ec.write, line));
          end
          if (ec.write && (!app_wdf_rdy_i || !app_wdf_wren_o || !app_wdf_end_o)) begin
            flag_error("write command without write data handshake");
          end
          if (ec.write && app_wdf_mask_o != lane_mask(ec.addr, ec.strb)) begin
            flag_error($sformatf("mask %h, expected %h", app_wdf_mask_o,
                                 lane_mask(ec.addr, ec.strb)));
          end
          if (ec.write && app_wdf_data_o[ec.addr[5:3]*64 +: 64] != ec.data) begin
            flag_error($sformatf("lane data %h, expected %h",
                                 app_wdf_data_o[ec.addr[5:3]*64 +: 64], ec.data));
          end
        end
      end
      response_check();
    end
    errors_o  = errors;
    pending_o = rsp_q.size();
  end

  // ********************
  // Response side
  // ********************
  task automatic response_check();
    exp_rsp_t er;
    if (s_axil_bvalid_o && s_axil_rvalid_o) begin
      flag_error("B and R valid in the same cycle");
    end
    if ((s_axil_bvalid_o && s_axil_bready_i) || (s_axil_rvalid_o && s_axil_rready_i)) begin
      if (rsp_q.size() == 0) begin
        flag_error("response with no request outstanding");
      end else begin
        er = rsp_q.pop_front();
        if (er.write != s_axil_bvalid_o) begin
          flag_error($sformatf("response out of order, expected write=%0b", er.write));
        end else if (er.write && s_axil_bresp_o != er.resp) begin
          flag_error($sformatf("bresp %0d, expected %0d", s_axil_bresp_o, er.resp));
        end else if (!er.write && (s_axil_rresp_o != er.resp ||
                     (er.resp == RESP_OKAY && s_axil_rdata_o != er.data))) begin
          flag_error($sformatf("rresp %0d rdata %h, expected %0d %h",
                               s_axil_rresp_o, s_axil_rdata_o, er.resp, er.data));
        end
      end
    end
  endtask

endmodule

// File: verification/tb_ddr_bridge.sv
`timescale 1ns/100ps
/*
 * Testbench for the AXI4-Lite to DDR4 bridge. Drives random AXI4-Lite
 * traffic and stands in for the memory controller on the native side.
 */
module tb_ddr_bridge;

  localparam int NUM_TXN      = 400;
  localparam int RESET_CYCLES = 10;
  localparam int CALIB_CYCLES = 30;
  localparam int MAX_CYCLES   = NUM_TXN * 40 + 100;

  logic         c0_ddr4_clk;
  logic         reset_i;
  logic         init_calib_complete_i;
  logic [31:0]  s_axil_awaddr_i;
  logic         s_axil_awvalid_i;
  logic         s_axil_awready_o;
  logic [63:0]  s_axil_wdata_i;
  logic [7:0]   s_axil_wstrb_i;
  logic         s_axil_wvalid_i;
  logic         s_axil_wready_o;
  logic [1:0]   s_axil_bresp_o;
  logic         s_axil_bvalid_o;
  logic         s_axil_bready_i;
  logic [31:0]  s_axil_araddr_i;
  logic         s_axil_arvalid_i;
  logic         s_axil_arready_o;
  logic [63:0]  s_axil_rdata_o;
  logic [1:0]   s_axil_rresp_o;
  logic         s_axil_rvalid_o;
  logic         s_axil_rready_i;
  logic [27:0]  app_addr_o;
  logic [2:0]   app_cmd_o;
  logic         app_en_o;
  logic         app_rdy_i;
  logic [511:0] app_wdf_data_o;
  logic [63:0]  app_wdf_mask_o;
  logic         app_wdf_wren_o;
  logic         app_wdf_end_o;
  logic         app_wdf_rdy_i;
  logic [511:0] app_rd_data_i;
  logic         app_rd_data_valid_i;

  int unsigned  cycle_cnt = 0;
  int           sent;
  int           err_cnt;
  int           pending;
  logic         aw_fire;
  logic         ar_fire;
  logic         timed_out;
  // Controller model lines, all zero until written
  logic [511:0] line_mem [logic [27:0]];
  logic [511:0] rd_data_q [$];
  int unsigned  rd_due_q [$];

  ddr_bridge uut (.*);

  bridge_checker u_checker (.errors_o(err_cnt), .pending_o(pending), .*);

  initial c0_ddr4_clk = 1'b0;
  always #10 c0_ddr4_clk = ~c0_ddr4_clk;

  always @(posedge c0_ddr4_clk) cycle_cnt <= cycle_cnt + 1;

  // A few lines, one of them near the top of the window, plus some out of range
  function automatic logic [31:0] pick_addr();
    logic [31:0] a;
    case ($urandom % 4)
      0: a = 32'h0000_0000;
      1: a = 32'h0000_0040;
      2: a = 32'h0012_3440;
      default: a = 32'h1FFF_FFC0;
    endcase
    a[5:3] = 3'($urandom);
    if ($urandom % 10 == 0) a[29 + ($urandom % 3)] = 1'b1;
    return a;
  endfunction

  // ********************
  // Controller model
  // ********************
  always @(negedge c0_ddr4_clk) begin
    logic [511:0] line;
    aw_fire = s_axil_awvalid_i && s_axil_awready_o;
    ar_fire = s_axil_arvalid_i && s_axil_arready_o;
    if (app_en_o && app_rdy_i) begin
      line = line_mem.exists(app_addr_o) ? line_mem[app_addr_o] : '0;
      if (app_cmd_o == 3'd0) begin
        for (int b = 0; b < 64; b++) begin
          if (!app_wdf_mask_o[b]) line[b*8 +: 8] = app_wdf_data_o[b*8 +: 8];
        end
        line_mem[app_addr_o] = line;
      end else begin
        rd_data_q.push_back(line);
        rd_due_q.push_back(cycle_cnt + 2 + ($urandom % 11));
      end
    end
  end

  // ********************
  // Stimulus
  // ********************
  always @(posedge c0_ddr4_clk) begin
    #2;
    app_rdy_i           = ($urandom % 4) != 0;
    app_wdf_rdy_i       = ($urandom % 5) != 0;
    s_axil_bready_i     = ($urandom % 3) != 0;
    s_axil_rready_i     = ($urandom % 3) != 0;
    app_rd_data_valid_i = 1'b0;
    // Read data leaves in command order once the head is due
    if (rd_due_q.size() != 0 && cycle_cnt >= rd_due_q[0]) begin
      void'(rd_due_q.pop_front());
      app_rd_data_i       = rd_data_q.pop_front();
      app_rd_data_valid_i = 1'b1;
    end
    if (cycle_cnt > RESET_CYCLES) begin
      if (aw_fire) begin
        s_axil_awvalid_i = 1'b0;
        s_axil_wvalid_i  = 1'b0;
      end
      if (!s_axil_awvalid_i && sent < NUM_TXN && $urandom % 2 == 0) begin
        s_axil_awaddr_i  = pick_addr();
        s_axil_wdata_i   = {$urandom, $urandom};
        s_axil_wstrb_i   = ($urandom % 3 == 0) ? 8'hFF : 8'($urandom);
        s_axil_awvalid_i = 1'b1;
        s_axil_wvalid_i  = 1'b1;
        sent++;
      end
      if (ar_fire) s_axil_arvalid_i = 1'b0;
      if (!s_axil_arvalid_i && sent < NUM_TXN && $urandom % 2 == 0) begin
        s_axil_araddr_i  = pick_addr();
        s_axil_arvalid_i = 1'b1;
        sent++;
      end
    end
  end

  initial begin
    void'($urandom(32'hc294_7177));
    sent                  = 0;
    aw_fire               = 1'b0;
    ar_fire               = 1'b0;
    timed_out             = 1'b0;
    reset_i               = 1'b1;
    init_calib_complete_i = 1'b0;
    s_axil_awaddr_i       = '0;
    s_axil_awvalid_i      = 1'b0;
    s_axil_wdata_i        = '0;
    s_axil_wstrb_i        = '0;
    s_axil_wvalid_i       = 1'b0;
    s_axil_bready_i       = 1'b0;
    s_axil_araddr_i       = '0;
    s_axil_arvalid_i      = 1'b0;
    s_axil_rready_i       = 1'b0;
    app_rdy_i             = 1'b0;
    app_wdf_rdy_i         = 1'b0;
    app_rd_data_i         = '0;
    app_rd_data_valid_i   = 1'b0;
    repeat (RESET_CYCLES) @(posedge c0_ddr4_clk);
    #2 reset_i = 1'b0;
    repeat (CALIB_CYCLES - RESET_CYCLES) @(posedge c0_ddr4_clk);
    #2 init_calib_complete_i = 1'b1;
    // Finished once every request is accepted and answered
    while (!timed_out && !(sent == NUM_TXN && !s_axil_awvalid_i && !s_axil_arvalid_i &&
           pending == 0)) begin
      @(posedge c0_ddr4_clk);
      if (cycle_cnt >= MAX_CYCLES) timed_out = 1'b1;
    end
    if (timed_out) begin
      $display("Timeout: run did not finish within %0d cycles, %0d responses missing",
               MAX_CYCLES, pending);
    end
    $display("Errors: %0d", err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: ddr_bridge.f
hw/ddr_bridge_pkg.sv
hw/mem_req_if.sv
hw/pipe_skid.sv
hw/axil_req_front.sv
hw/app_addr_map.sv
hw/app_cmd_issue.sv
hw/ddr_bridge.sv
verification/bridge_checker.sv
verification/tb_ddr_bridge.sv

// File: Makefile
TOP := tb_ddr_bridge
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f ddr_bridge.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
